// ==== verilog/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    parameter int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // decode stage to execute stage
    typedef struct packed {
        logic      illegal;
        word_t     pc;
        word_t     inst;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rd_wen;
        alu_op_e   alu_op;
        logic      a_is_pc;
        logic      b_is_imm;
        word_t     imm;
    } dec_t;

    // one record per retired instruction
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      rd_wen;
        reg_addr_t rd;
        word_t     rd_wdata;
        logic      illegal;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_valid,
    output logic o_ready,
    input  wire  T i_data,
    output logic o_valid,
    input  wire  i_ready,
    output T     o_data
);

    logic full;
    T     data_q;

    // take new data when empty or when draining this cycle
    assign o_ready = i_ready || !full;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full <= 1'b0;
        end else if (o_ready) begin
            full <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

    assign o_valid = full;
    assign o_data  = data_q;

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_exec_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire word_t i_inst,
    input  wire        i_accept,
    output dec_t       o_dec
);

    word_t      pc;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    logic       shift;
    logic       legal;
    alu_op_e    f3_op;
    word_t      imm_i;
    word_t      imm_u;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_PC;
        end else if (i_accept) begin
            pc <= pc + 32'd4;
        end
    end

    assign opcode  = i_inst[6:0];
    assign funct3  = i_inst[14:12];
    assign funct7  = i_inst[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign shift   = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign imm_i   = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u   = {i_inst[31:12], 12'h000};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = f7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        legal          = 1'b0;
        o_dec.pc       = pc;
        o_dec.inst     = i_inst;
        o_dec.rs1      = i_inst[19:15];
        o_dec.rs2      = i_inst[24:20];
        o_dec.rd       = i_inst[11:7];
        o_dec.alu_op   = f3_op;
        o_dec.a_is_pc  = 1'b0;
        o_dec.b_is_imm = 1'b1;
        o_dec.imm      = imm_i;
        case (opcode)
            OPC_OP: begin
                o_dec.b_is_imm = 1'b0;
                legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                if (funct3 == 3'b000 && f7_alt) begin
                    o_dec.alu_op = ALU_SUB;
                end
            end
            // immediate shifts carry funct7 in the upper imm bits
            OPC_OP_IMM: legal = !shift || f7_zero || (f7_alt && funct3 == 3'b101);
            OPC_LUI: begin
                legal        = 1'b1;
                o_dec.alu_op = ALU_PASS_B;
                o_dec.imm    = imm_u;
            end
            OPC_AUIPC: begin
                legal         = 1'b1;
                o_dec.alu_op  = ALU_ADD;
                o_dec.a_is_pc = 1'b1;
                o_dec.imm     = imm_u;
            end
            default: legal = 1'b0;
        endcase
        o_dec.illegal = !legal;
        o_dec.rd_wen  = legal;
        if (!legal) begin
            o_dec.alu_op = ALU_ADD;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_exec_pkg::*;
(
    input  wire            i_clk,
    input  wire reg_addr_t i_rs1,
    input  wire reg_addr_t i_rs2,
    output word_t          o_rs1_data,
    output word_t          o_rs2_data,
    input  wire            i_wen,
    input  wire reg_addr_t i_rd,
    input  wire word_t     i_wdata
);

    word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 may hold a written value, masked on read
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu
    import rv_exec_pkg::*;
(
    input  wire alu_op_e i_op,
    input  wire word_t   i_a,
    input  wire word_t   i_b,
    output word_t        o_result
);

    logic       sub;
    word_t      b_inv;
    word_t      sum;
    logic       carry;
    logic       lt;
    logic       ltu;
    logic [4:0] shamt;
    logic       sign;
    word_t      sl [0:5];
    word_t      sr [0:5];

    // compares reuse the subtractor
    assign sub   = (i_op == ALU_SUB) || (i_op == ALU_SLT) || (i_op == ALU_SLTU);
    assign b_inv = i_b ^ {XLEN{sub}};
    assign {carry, sum} = {1'b0, i_a} + {1'b0, b_inv} + {{XLEN{1'b0}}, sub};

    // no borrow out means a >= b unsigned
    assign ltu = !carry;
    assign lt  = (i_a[XLEN-1] ^ i_b[XLEN-1]) ? i_a[XLEN-1] : sum[XLEN-1];

    assign shamt = i_b[4:0];
    assign sign  = (i_op == ALU_SRA) && i_a[XLEN-1];

    // five levels per direction, 16 8 4 2 1
    always_comb begin
        sl[5] = i_a;
        sr[5] = i_a;
        for (int k = 4; k >= 0; k--) begin
            sl[k] = shamt[k] ? (sl[k+1] << (1 << k)) : sl[k+1];
            sr[k] = shamt[k] ? word_t'({{XLEN{sign}}, sr[k+1]} >> (1 << k)) : sr[k+1];
        end
    end

    always_comb begin
        case (i_op)
            ALU_ADD,
            ALU_SUB:    o_result = sum;
            ALU_SLL:    o_result = sl[0];
            ALU_SLT:    o_result = word_t'(lt);
            ALU_SLTU:   o_result = word_t'(ltu);
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SRL,
            ALU_SRA:    o_result = sr[0];
            ALU_OR:     o_result = i_a | i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = sum;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import rv_exec_pkg::*;
(
    input  wire       i_clk,
    input  wire dec_t i_dec,
    input  wire       i_commit,
    output retire_t   o_ret
);

    word_t rs1_data;
    word_t rs2_data;
    word_t op_a;
    word_t op_b;
    word_t result;

    // write lands on the edge the record moves on
    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rs1      (i_dec.rs1),
        .i_rs2      (i_dec.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wen      (i_commit && i_dec.rd_wen),
        .i_rd       (i_dec.rd),
        .i_wdata    (result)
    );

    assign op_a = i_dec.a_is_pc ? i_dec.pc : rs1_data;
    assign op_b = i_dec.b_is_imm ? i_dec.imm : rs2_data;

    int_alu u_int_alu (
        .i_op     (i_dec.alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (result)
    );

    always_comb begin
        o_ret.pc       = i_dec.pc;
        o_ret.inst     = i_dec.inst;
        o_ret.rd_wen   = i_dec.rd_wen;
        o_ret.rd       = i_dec.rd;
        // zero when nothing is written back
        o_ret.rd_wdata = i_dec.rd_wen ? result : '0;
        o_ret.illegal  = i_dec.illegal;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core
    import rv_exec_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_inst_valid,
    output logic       o_inst_ready,
    input  wire word_t i_inst,
    output logic       o_ret_valid,
    input  wire        i_ret_ready,
    output retire_t    o_ret
);

    dec_t    dec_in;
    dec_t    dec_out;
    logic    dec_valid;
    logic    ret_in_ready;
    retire_t ret_in;

    inst_decoder #(
        .RESET_PC (RESET_PC)
    ) u_decoder (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_inst   (i_inst),
        .i_accept (i_inst_valid & o_inst_ready),
        .o_dec    (dec_in)
    );

    pipe_reg #(.T(dec_t)) dec_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_inst_valid),
        .o_ready (o_inst_ready),
        .i_data  (dec_in),
        .o_valid (dec_valid),
        .i_ready (ret_in_ready),
        .o_data  (dec_out)
    );

    exec_stage u_exec (
        .i_clk    (i_clk),
        .i_dec    (dec_out),
        .i_commit (dec_valid & ret_in_ready),
        .o_ret    (ret_in)
    );

    pipe_reg #(.T(retire_t)) ret_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (dec_valid),
        .o_ready (ret_in_ready),
        .i_data  (ret_in),
        .o_valid (o_ret_valid),
        .i_ready (i_ret_ready),
        .o_data  (o_ret)
    );

endmodule

`default_nettype wire

// ==== verif/rv_exec_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_assertions
    import rv_exec_pkg::*;
(
    input wire          i_clk,
    input wire          i_rst_n,
    input wire          o_ret_valid,
    input wire          i_ret_ready,
    input wire retire_t o_ret
);

    int fail_count = 0;

    // stalled record holds until taken
    a_ret_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ret_valid && !i_ret_ready |=> o_ret_valid && $stable(o_ret))
        else begin
            fail_count++;
            $error("o_ret changed while stalled");
        end

    a_illegal_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ret_valid && o_ret.illegal |-> !o_ret.rd_wen)
        else begin
            fail_count++;
            $error("illegal record retired with rd_wen set");
        end

    a_reset_idle: assert property (@(posedge i_clk) !i_rst_n |-> !o_ret_valid)
        else begin
            fail_count++;
            $error("o_ret_valid high during reset");
        end

endmodule

bind rv_exec_core rv_exec_assertions u_assertions (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .o_ret_valid (o_ret_valid),
    .i_ret_ready (i_ret_ready),
    .o_ret       (o_ret)
);

`default_nettype wire

// ==== include/rv_exec_ref_model.svh ====
`ifndef RV_EXEC_REF_MODEL_SVH
`define RV_EXEC_REF_MODEL_SVH

// kind 0 OP, 1 OP-IMM, 2 LUI, 3 AUIPC, anything else a raw random word
function automatic word_t random_inst(int unsigned kind);
    word_t      inst;
    logic [2:0] f3;
    inst = $urandom();
    f3   = inst[14:12];
    case (kind)
        0: begin
            inst[6:0]   = OPC_OP;
            inst[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && inst[30]) ? 7'h20 : 7'h00;
        end
        1: begin
            inst[6:0] = OPC_OP_IMM;
            if (f3 == 3'b001 || f3 == 3'b101) begin
                inst[31:25] = (f3 == 3'b101 && inst[30]) ? 7'h20 : 7'h00;
            end
        end
        2: inst[6:0] = OPC_LUI;
        3: inst[6:0] = OPC_AUIPC;
        default: ;
    endcase
    return inst;
endfunction

function automatic logic inst_is_legal(word_t inst);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = inst[14:12];
    f7 = inst[31:25];
    case (inst[6:0])
        OPC_LUI, OPC_AUIPC: return 1'b1;
        OPC_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        OPC_OP_IMM: return (f3 != 3'b001 && f3 != 3'b101) || f7 == 7'h00
                           || (f7 == 7'h20 && f3 == 3'b101);
        default:    return 1'b0;
    endcase
endfunction

// expected record from the shadow values of rs1 and rs2
function automatic retire_t expected_retire(word_t inst, word_t pc, word_t rs1_val,
                                            word_t rs2_val);
    retire_t r;
    word_t   b;
    word_t   res;
    logic    alt;
    b   = (inst[6:0] == OPC_OP) ? rs2_val : {{20{inst[31]}}, inst[31:20]};
    alt = inst[30];
    case (inst[14:12])
        3'b000:  res = (inst[6:0] == OPC_OP && alt) ? rs1_val - b : rs1_val + b;
        3'b001:  res = rs1_val << b[4:0];
        3'b010:  res = word_t'($signed(rs1_val) < $signed(b));
        3'b011:  res = word_t'(rs1_val < b);
        3'b100:  res = rs1_val ^ b;
        3'b101:  res = alt ? word_t'($signed(rs1_val) >>> b[4:0]) : rs1_val >> b[4:0];
        3'b110:  res = rs1_val | b;
        default: res = rs1_val & b;
    endcase
    if (inst[6:0] == OPC_LUI) begin
        res = {inst[31:12], 12'h000};
    end else if (inst[6:0] == OPC_AUIPC) begin
        res = pc + {inst[31:12], 12'h000};
    end
    r.pc       = pc;
    r.inst     = inst;
    r.illegal  = !inst_is_legal(inst);
    r.rd_wen   = !r.illegal;
    r.rd       = inst[11:7];
    r.rd_wdata = r.rd_wen ? res : '0;
    return r;
endfunction

`endif

// ==== verif/rv_exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core_tb
    import rv_exec_pkg::*;
();

    localparam word_t RESET_PC = '0;
    localparam int    TIMEOUT  = 200;

    logic    i_clk;
    logic    i_rst_n;
    logic    i_inst_valid;
    logic    o_inst_ready;
    word_t   i_inst;
    logic    o_ret_valid;
    logic    i_ret_ready;
    retire_t o_ret;

    word_t     shadow [32];
    word_t     model_pc;
    retire_t   exp_q [$];
    int        acc_q [$];
    retire_t   exp_rec;
    int        acc_cycle;
    int        cycle;
    int        sent;
    int        ret_count;
    int        checks;
    int        errors;
    int        tests;
    logic      bp_on;
    logic      lat_check;
    reg_addr_t prev_rd;

    `include "rv_exec_ref_model.svh"

    rv_exec_core i_rv_exec_core (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .o_inst_ready (o_inst_ready),
        .i_inst       (i_inst),
        .o_ret_valid  (o_ret_valid),
        .i_ret_ready  (i_ret_ready),
        .o_ret        (o_ret)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        // sink stalls roughly one cycle in four
        i_ret_ready <= bp_on ? (($urandom() % 4) != 0) : 1'b1;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        check_word("o_ret.pc", exp.pc, act.pc);
        check_word("o_ret.inst", exp.inst, act.inst);
        check_word("o_ret.rd_wen", word_t'(exp.rd_wen), word_t'(act.rd_wen));
        check_word("o_ret.rd", word_t'(exp.rd), word_t'(act.rd));
        check_word("o_ret.rd_wdata", exp.rd_wdata, act.rd_wdata);
        check_word("o_ret.illegal", word_t'(exp.illegal), word_t'(act.illegal));
    endtask

    // retire monitor
    always @(posedge i_clk) begin
        if (i_rst_n && o_ret_valid && i_ret_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a record retired with no instruction outstanding");
            end else begin
                exp_rec   = exp_q.pop_front();
                acc_cycle = acc_q.pop_front();
                check_retire(exp_rec, o_ret);
                check_word("retire pc order", RESET_PC + 32'd4 * ret_count, o_ret.pc);
                if (lat_check) begin
                    check_word("retire latency", 32'd2, word_t'(cycle - acc_cycle));
                end
            end
            ret_count++;
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Finished with errors");
        $finish;
    endtask

    // called on a rising edge and returns on the edge of the transfer
    task automatic send_inst(input word_t inst);
        int      cnt;
        logic    done;
        retire_t exp;
        i_inst_valid <= 1'b1;
        i_inst       <= inst;
        done = 1'b0;
        cnt  = 0;
        while (!done && cnt < TIMEOUT) begin
            @(posedge i_clk);
            done = o_inst_ready;
            cnt++;
        end
        if (!done) begin
            stop_on_timeout("no instruction was accepted in time");
        end else begin
            exp = expected_retire(inst, model_pc, shadow[inst[19:15]], shadow[inst[24:20]]);
            if (exp.rd_wen && exp.rd != 5'd0) begin
                shadow[exp.rd] = exp.rd_wdata;
            end
            exp_q.push_back(exp);
            acc_q.push_back(cycle);
            model_pc = model_pc + 32'd4;
            sent++;
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < TIMEOUT) begin
            @(posedge i_clk);
            cnt++;
        end
        if (exp_q.size() != 0) begin
            stop_on_timeout("no retire arrived in time");
        end
    endtask

    function automatic word_t next_inst(input int mode, input int idx);
        word_t inst;
        case (mode)
            1: inst = random_inst($urandom() % 2);
            2: inst = random_inst(2 + $urandom() % 2);
            3: begin
                // chain on the previous destination and mix in x0 writes
                inst = random_inst($urandom() % 2);
                inst[19:15] = prev_rd;
                if ($urandom() % 2) begin
                    inst[24:20] = prev_rd;
                end
                if (idx % 8 == 3) begin
                    inst[11:7] = 5'd0;
                end
                prev_rd = inst[11:7];
            end
            4: begin
                if (idx % 2 == 0) begin
                    do begin
                        inst = random_inst(4);
                    end while (inst_is_legal(inst));
                end else begin
                    inst = random_inst($urandom() % 2);
                end
            end
            default: inst = random_inst($urandom() % 5);
        endcase
        return inst;
    endfunction

    task automatic run_test(input string name, input int mode, input int n);
        int    err0;
        int    i;
        word_t inst;
        err0 = errors;
        for (i = 0; i < n; i++) begin
            if (mode == 0) begin
                // LUI then ADDI on the same register
                inst = random_inst(2);
                inst[11:7] = reg_addr_t'(i + 1);
                send_inst(inst);
                inst = random_inst(1);
                inst[14:12] = 3'b000;
                inst[11:7]  = reg_addr_t'(i + 1);
                inst[19:15] = reg_addr_t'(i + 1);
                send_inst(inst);
            end else begin
                send_inst(next_inst(mode, i));
            end
        end
        i_inst_valid <= 1'b0;
        wait_drain();
        @(posedge i_clk);
        tests++;
        $display("test %s: %0d instructions, %0d errors", name, n, errors - err0);
    endtask

    initial begin
        void'($urandom(32'h74583b85));
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_ret_ready  = 1'b1;
        bp_on        = 1'b1;
        lat_check    = 1'b0;
        prev_rd      = 5'd1;
        model_pc     = RESET_PC;
        cycle        = 0;
        sent         = 0;
        ret_count    = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);

        run_test("prime_registers", 0, 31);
        run_test("alu_operations", 1, 300);
        run_test("lui_auipc", 2, 100);
        run_test("dependencies_x0", 3, 120);
        run_test("illegal_instructions", 4, 100);
        run_test("back_pressure", 5, 300);

        // ready held high for the latency run
        bp_on = 1'b0;
        repeat (2) @(posedge i_clk);
        lat_check = 1'b1;
        run_test("latency", 5, 100);
        lat_check = 1'b0;

        if (ret_count != sent) begin
            errors++;
            $display("%0d records retired for %0d instructions sent", ret_count, sent);
        end
        errors += i_rv_exec_core.u_assertions.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
verilog/rv_exec_pkg.sv
verilog/pipe_reg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/int_alu.sv
verilog/exec_stage.sv
verilog/rv_exec_core.sv
verif/rv_exec_assertions.sv
verif/rv_exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec_core

sources:
  - files:
      - verilog/rv_exec_pkg.sv
      - verilog/pipe_reg.sv
      - verilog/inst_decoder.sv
      - verilog/reg_file.sv
      - verilog/int_alu.sv
      - verilog/exec_stage.sv
      - verilog/rv_exec_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/rv_exec_assertions.sv
      - verif/rv_exec_core_tb.sv
